//--- mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// word-address widths of the two memories
`define MIPS_IM_AW 8
`define MIPS_DM_AW 8

// architectural register count
`define MIPS_NREG 32

`endif

//--- mips_isa_pkg.sv
package mips_isa_pkg;

	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_jal   = 6'h03,
		op_beq   = 6'h04,
		op_addiu = 6'h09,
		op_ori   = 6'h0d,
		op_lui   = 6'h0f,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_e;

	// funct field of op_rtype
	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_slt  = 6'h2a
	} funct_e;

	typedef struct packed {
		opcode_e    op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e     funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_e     op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	// one instruction word, read as R or I format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

endpackage

//--- mips_ctrl_pkg.sv
package mips_ctrl_pkg;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_sll
	} alu_op_e;

	typedef enum logic [1:0] {ext_zero, ext_sign, ext_upper} ext_mode_e;
	typedef enum logic [1:0] {wb_alu, wb_mem, wb_link} wb_sel_e;
	typedef enum logic [1:0] {npc_seq, npc_beq, npc_jump} npc_mode_e;

	// all-zero word is a bubble
	typedef struct packed {
		alu_op_e    alu_op;
		logic       alu_src_imm;
		ext_mode_e  ext_mode;
		logic       uses_rs;
		logic       uses_rt;
		logic       reg_write;
		logic [4:0] wr_addr;
		logic       mem_read;
		logic       mem_write;
		wb_sel_e    wb_sel;
		npc_mode_e  npc_mode;
	} ctrl_t;

	typedef enum logic [1:0] {
		fwd_d_orig, fwd_d_m_alu, fwd_d_m_link, fwd_d_w_data
	} fwd_d_e;

	typedef enum logic [1:0] {
		fwd_e_orig, fwd_e_m_alu, fwd_e_m_link, fwd_e_w_data
	} fwd_e_e;

	typedef enum logic {fwd_m_orig, fwd_m_w_data} fwd_m_e;

endpackage

//--- mips_hazard_if.sv
`timescale 1ns/10ps

interface mips_hazard_if;
	import mips_ctrl_pkg::*;

	logic [4:0] d_rs, d_rt;
	logic       d_uses_rs, d_uses_rt, d_is_branch;
	logic [4:0] e_rs, e_rt, e_wr_addr;
	logic       e_reg_write, e_mem_read;
	logic [4:0] m_rt, m_wr_addr;
	logic       m_reg_write, m_mem_read;
	wb_sel_e    m_wb_sel;
	logic [4:0] w_wr_addr;
	logic       w_reg_write;

	logic       stall;
	fwd_d_e     fwd_d1, fwd_d2;
	fwd_e_e     fwd_e1, fwd_e2;
	fwd_m_e     fwd_m;

	modport unit (
		input  d_rs, d_rt, d_uses_rs, d_uses_rt, d_is_branch,
		input  e_rs, e_rt, e_wr_addr, e_reg_write, e_mem_read,
		input  m_rt, m_wr_addr, m_reg_write, m_mem_read, m_wb_sel,
		input  w_wr_addr, w_reg_write,
		output stall, fwd_d1, fwd_d2, fwd_e1, fwd_e2, fwd_m
	);

	modport pipe (
		output d_rs, d_rt, d_uses_rs, d_uses_rt, d_is_branch,
		output e_rs, e_rt, e_wr_addr, e_reg_write, e_mem_read,
		output m_rt, m_wr_addr, m_reg_write, m_mem_read, m_wb_sel,
		output w_wr_addr, w_reg_write,
		input  stall, fwd_d1, fwd_d2, fwd_e1, fwd_e2, fwd_m
	);

endinterface

//--- mips_decode.sv
`timescale 1ns/10ps

module mips_decode (
	input  mips_isa_pkg::instr_u instr,
	output mips_ctrl_pkg::ctrl_t ctrl
);
	import mips_isa_pkg::*;
	import mips_ctrl_pkg::*;

	always_comb begin
		ctrl = '0;
		case (instr.r.op)
			op_rtype: begin
				ctrl.reg_write = 1'b1;
				ctrl.wr_addr   = instr.r.rd;
				ctrl.uses_rs   = 1'b1;
				ctrl.uses_rt   = 1'b1;
				case (instr.r.funct)
					fn_addu: ctrl.alu_op = alu_add;
					fn_subu: ctrl.alu_op = alu_sub;
					fn_and:  ctrl.alu_op = alu_and;
					fn_or:   ctrl.alu_op = alu_or;
					fn_slt:  ctrl.alu_op = alu_slt;
					fn_sll: begin
						ctrl.alu_op  = alu_sll;
						ctrl.uses_rs = 1'b0;
					end
					default: ctrl = '0;
				endcase
			end
			op_addiu, op_ori, op_lui, op_lw: begin
				ctrl.reg_write   = 1'b1;
				ctrl.wr_addr     = instr.i.rt;
				ctrl.alu_src_imm = 1'b1;
				ctrl.uses_rs     = 1'b1;
				ctrl.ext_mode    = ext_sign;
				if (instr.i.op == op_ori) begin
					ctrl.alu_op   = alu_or;
					ctrl.ext_mode = ext_zero;
				end
				// lui ors the shifted immediate into a zero operand
				if (instr.i.op == op_lui) begin
					ctrl.alu_op   = alu_or;
					ctrl.ext_mode = ext_upper;
					ctrl.uses_rs  = 1'b0;
				end
				if (instr.i.op == op_lw) begin
					ctrl.mem_read = 1'b1;
					ctrl.wb_sel   = wb_mem;
				end
			end
			op_sw: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.ext_mode    = ext_sign;
				ctrl.uses_rs     = 1'b1;
				ctrl.uses_rt     = 1'b1;
				ctrl.mem_write   = 1'b1;
			end
			op_beq: begin
				ctrl.uses_rs  = 1'b1;
				ctrl.uses_rt  = 1'b1;
				ctrl.npc_mode = npc_beq;
			end
			op_j: ctrl.npc_mode = npc_jump;
			op_jal: begin
				ctrl.npc_mode  = npc_jump;
				ctrl.reg_write = 1'b1;
				ctrl.wr_addr   = 5'd31;
				ctrl.wb_sel    = wb_link;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

//--- mips_hazard.sv
`timescale 1ns/10ps

module mips_hazard (
	mips_hazard_if.unit hz
);
	import mips_ctrl_pkg::*;

	logic e_load, e_alu, m_load, m_fwd_ok, m_is_link;

	function automatic logic src_hit(logic we, logic [4:0] wa, logic [4:0] ra);
		return we && (wa != 5'd0) && (wa == ra);
	endfunction

	// does the instruction in D read a register written by this source
	function automatic logic d_reads(logic we, logic [4:0] wa, logic uses_rs, logic uses_rt,
			logic [4:0] rs, logic [4:0] rt);
		return (uses_rs && src_hit(we, wa, rs)) || (uses_rt && src_hit(we, wa, rt));
	endfunction

	assign e_load    = hz.e_reg_write && hz.e_mem_read;
	assign e_alu     = hz.e_reg_write && !hz.e_mem_read;
	assign m_load    = hz.m_reg_write && hz.m_mem_read;
	// load data only exists in W, so M never forwards a load
	assign m_fwd_ok  = hz.m_reg_write && !hz.m_mem_read;
	assign m_is_link = (hz.m_wb_sel == wb_link);

	assign hz.stall =
		d_reads(e_load, hz.e_wr_addr, hz.d_uses_rs, hz.d_uses_rt, hz.d_rs, hz.d_rt) ||
		(hz.d_is_branch &&
			(d_reads(e_alu, hz.e_wr_addr, 1'b1, 1'b1, hz.d_rs, hz.d_rt) ||
			 d_reads(m_load, hz.m_wr_addr, 1'b1, 1'b1, hz.d_rs, hz.d_rt)));

	always_comb begin
		hz.fwd_d1 = fwd_d_orig;
		hz.fwd_d2 = fwd_d_orig;
		if (hz.d_is_branch && src_hit(hz.w_reg_write, hz.w_wr_addr, hz.d_rs))
			hz.fwd_d1 = fwd_d_w_data;
		if (hz.d_is_branch && src_hit(hz.w_reg_write, hz.w_wr_addr, hz.d_rt))
			hz.fwd_d2 = fwd_d_w_data;
		if (src_hit(m_fwd_ok, hz.m_wr_addr, hz.d_rs))
			hz.fwd_d1 = m_is_link ? fwd_d_m_link : fwd_d_m_alu;
		if (src_hit(m_fwd_ok, hz.m_wr_addr, hz.d_rt))
			hz.fwd_d2 = m_is_link ? fwd_d_m_link : fwd_d_m_alu;
	end

	always_comb begin
		hz.fwd_e1 = fwd_e_orig;
		hz.fwd_e2 = fwd_e_orig;
		if (src_hit(hz.w_reg_write, hz.w_wr_addr, hz.e_rs))
			hz.fwd_e1 = fwd_e_w_data;
		if (src_hit(hz.w_reg_write, hz.w_wr_addr, hz.e_rt))
			hz.fwd_e2 = fwd_e_w_data;
		if (src_hit(m_fwd_ok, hz.m_wr_addr, hz.e_rs))
			hz.fwd_e1 = m_is_link ? fwd_e_m_link : fwd_e_m_alu;
		if (src_hit(m_fwd_ok, hz.m_wr_addr, hz.e_rt))
			hz.fwd_e2 = m_is_link ? fwd_e_m_link : fwd_e_m_alu;
	end

	assign hz.fwd_m = src_hit(hz.w_reg_write, hz.w_wr_addr, hz.m_rt) ? fwd_m_w_data : fwd_m_orig;

endmodule

//--- mips_rf.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module mips_rf (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  ra1,
	input  logic [4:0]  ra2,
	input  logic        we,
	input  logic [4:0]  wa,
	input  logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regs [`MIPS_NREG];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `MIPS_NREG; i++)
				regs[i] <= '0;
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	// write-through so D sees the value retiring this cycle
	assign rd1 = (ra1 == 5'd0) ? 32'd0 : (we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? 32'd0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

//--- mips.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module mips (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   imem_we,
	input  logic [`MIPS_IM_AW-1:0] imem_addr,
	input  logic [31:0]            imem_wdata,
	output logic                   wb_en,
	output logic [31:0]            wb_pc,
	output logic [4:0]             wb_addr,
	output logic [31:0]            wb_data,
	output logic                   dm_we,
	output logic [31:0]            dm_addr,
	output logic [31:0]            dm_wdata
);
	import mips_isa_pkg::*;
	import mips_ctrl_pkg::*;

	logic [31:0] imem [2**`MIPS_IM_AW];
	logic [31:0] dmem [2**`MIPS_DM_AW];

	logic [31:0] pc, pc_next, f_instr;
	logic [31:0] d_pc, e_pc, m_pc, w_pc;
	instr_u      d_instr, e_instr;
	ctrl_t       d_ctrl, e_ctrl, m_ctrl, w_ctrl;
	logic [31:0] d_rd1, d_rd2, d_op1, d_op2, d_pc4, d_br_off;
	logic [31:0] e_a, e_b, e_op1, e_op2, e_ext, e_alu_a, e_alu_b, e_alu;
	logic [4:0]  m_rt;
	logic [31:0] m_alu, m_sd, m_wdata, m_rdata, m_link;
	logic [31:0] w_alu, w_mem, w_link, w_data;

	mips_hazard_if hz ();

	mips_hazard u_hazard (.hz(hz.unit));

	// data memory powers up cleared
	initial begin
		for (int i = 0; i < 2**`MIPS_DM_AW; i++)
			dmem[i] = '0;
	end

	// program load only while the core is held in reset
	always_ff @(posedge clk) begin
		if (!rst_n && imem_we)
			imem[imem_addr] <= imem_wdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= `MIPS_RESET_PC;
		else if (!hz.stall)
			pc <= pc_next;
	end

	assign f_instr = imem[pc[`MIPS_IM_AW+1:2]];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			d_instr <= '0;
		else if (!hz.stall)
			d_instr <= f_instr;
	end

	always_ff @(posedge clk) begin
		if (!hz.stall)
			d_pc <= pc;
	end

	mips_decode u_decode (.instr(d_instr), .ctrl(d_ctrl));

	mips_rf u_rf (
		.clk(clk), .rst_n(rst_n),
		.ra1(d_instr.r.rs), .ra2(d_instr.r.rt),
		.we(w_ctrl.reg_write), .wa(w_ctrl.wr_addr), .wd(w_data),
		.rd1(d_rd1), .rd2(d_rd2)
	);

	always_comb begin
		case (hz.fwd_d1)
			fwd_d_m_alu:  d_op1 = m_alu;
			fwd_d_m_link: d_op1 = m_link;
			fwd_d_w_data: d_op1 = w_data;
			default:      d_op1 = d_rd1;
		endcase
		case (hz.fwd_d2)
			fwd_d_m_alu:  d_op2 = m_alu;
			fwd_d_m_link: d_op2 = m_link;
			fwd_d_w_data: d_op2 = w_data;
			default:      d_op2 = d_rd2;
		endcase
	end

	// branches and jumps resolve here, the fetch in flight is the delay slot
	assign d_pc4    = d_pc + 32'd4;
	assign d_br_off = {{14{d_instr.i.imm[15]}}, d_instr.i.imm, 2'b00};

	always_comb begin
		pc_next = pc + 32'd4;
		case (d_ctrl.npc_mode)
			npc_beq:  if (d_op1 == d_op2) pc_next = d_pc4 + d_br_off;
			npc_jump: pc_next = {d_pc4[31:28], d_instr.i.rs, d_instr.i.rt, d_instr.i.imm, 2'b00};
			default:  pc_next = pc + 32'd4;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			e_ctrl <= '0;
		else
			e_ctrl <= hz.stall ? '0 : d_ctrl;
	end

	always_ff @(posedge clk) begin
		e_pc    <= d_pc;
		e_instr <= d_instr;
		e_a     <= d_op1;
		e_b     <= d_op2;
	end

	always_comb begin
		case (hz.fwd_e1)
			fwd_e_m_alu:  e_op1 = m_alu;
			fwd_e_m_link: e_op1 = m_link;
			fwd_e_w_data: e_op1 = w_data;
			default:      e_op1 = e_a;
		endcase
		case (hz.fwd_e2)
			fwd_e_m_alu:  e_op2 = m_alu;
			fwd_e_m_link: e_op2 = m_link;
			fwd_e_w_data: e_op2 = w_data;
			default:      e_op2 = e_b;
		endcase
	end

	always_comb begin
		case (e_ctrl.ext_mode)
			ext_sign:  e_ext = {{16{e_instr.i.imm[15]}}, e_instr.i.imm};
			ext_upper: e_ext = {e_instr.i.imm, 16'd0};
			default:   e_ext = {16'd0, e_instr.i.imm};
		endcase
	end

	assign e_alu_a = e_ctrl.uses_rs ? e_op1 : 32'd0;
	assign e_alu_b = e_ctrl.alu_src_imm ? e_ext : e_op2;

	always_comb begin
		case (e_ctrl.alu_op)
			alu_sub: e_alu = e_alu_a - e_alu_b;
			alu_and: e_alu = e_alu_a & e_alu_b;
			alu_or:  e_alu = e_alu_a | e_alu_b;
			alu_slt: e_alu = {31'd0, $signed(e_alu_a) < $signed(e_alu_b)};
			alu_sll: e_alu = e_alu_b << e_instr.r.shamt;
			default: e_alu = e_alu_a + e_alu_b;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			m_ctrl <= '0;
		else
			m_ctrl <= e_ctrl;
	end

	always_ff @(posedge clk) begin
		m_pc  <= e_pc;
		m_rt  <= e_instr.r.rt;
		m_alu <= e_alu;
		m_sd  <= e_op2;
	end

	assign m_link  = m_pc + 32'd8;
	assign m_wdata = (hz.fwd_m == fwd_m_w_data) ? w_data : m_sd;
	assign m_rdata = dmem[m_alu[`MIPS_DM_AW+1:2]];

	always @(posedge clk) begin
		if (m_ctrl.mem_write)
			dmem[m_alu[`MIPS_DM_AW+1:2]] <= m_wdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			w_ctrl <= '0;
		else
			w_ctrl <= m_ctrl;
	end

	always_ff @(posedge clk) begin
		w_pc  <= m_pc;
		w_alu <= m_alu;
		w_mem <= m_rdata;
	end

	assign w_link = w_pc + 32'd8;

	always_comb begin
		case (w_ctrl.wb_sel)
			wb_mem:  w_data = w_mem;
			wb_link: w_data = w_link;
			default: w_data = w_alu;
		endcase
	end

	// stage information for the hazard unit
	assign hz.d_rs        = d_instr.r.rs;
	assign hz.d_rt        = d_instr.r.rt;
	assign hz.d_uses_rs   = d_ctrl.uses_rs;
	assign hz.d_uses_rt   = d_ctrl.uses_rt;
	assign hz.d_is_branch = (d_ctrl.npc_mode == npc_beq);
	assign hz.e_rs        = e_instr.r.rs;
	assign hz.e_rt        = e_instr.r.rt;
	assign hz.e_wr_addr   = e_ctrl.wr_addr;
	assign hz.e_reg_write = e_ctrl.reg_write;
	assign hz.e_mem_read  = e_ctrl.mem_read;
	assign hz.m_rt        = m_rt;
	assign hz.m_wr_addr   = m_ctrl.wr_addr;
	assign hz.m_reg_write = m_ctrl.reg_write;
	assign hz.m_mem_read  = m_ctrl.mem_read;
	assign hz.m_wb_sel    = m_ctrl.wb_sel;
	assign hz.w_wr_addr   = w_ctrl.wr_addr;
	assign hz.w_reg_write = w_ctrl.reg_write;

	assign wb_en    = w_ctrl.reg_write && (w_ctrl.wr_addr != 5'd0);
	assign wb_pc    = w_pc;
	assign wb_addr  = w_ctrl.wr_addr;
	assign wb_data  = w_data;
	assign dm_we    = m_ctrl.mem_write;
	assign dm_addr  = m_alu;
	assign dm_wdata = m_wdata;

endmodule

//--- mips_asserts.sv
`timescale 1ns/10ps

module mips_asserts (
	input logic       clk,
	input logic       rst_n,
	input logic       wb_en,
	input logic [4:0] wb_addr,
	input logic       dm_we,
	input logic       stall
);

	// trace ports stay quiet while the core is held in reset
	a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> (!wb_en && !dm_we))
		else $error("trace pulse while rst_n is low");

	a_no_r0_retire: assert property (@(posedge clk) disable iff (!rst_n)
		wb_en |-> (wb_addr != 5'd0))
		else $error("retire pulse with r0 as target");

	// load feeding a branch is the longest hazard, two bubbles
	a_stall_bound: assert property (@(posedge clk) disable iff (!rst_n)
		(stall && $past(stall)) |=> !stall)
		else $error("stall held for more than two cycles");

endmodule

//--- tb_mips.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module tb_clock (
	output logic clk
);
	initial clk = 1'b0;
	always #2 clk = ~clk;
endmodule

module tb_mips;
	import mips_isa_pkg::*;

	localparam int PROG_LEN = 200;
	localparam int END_PC = (PROG_LEN - 2) * 4;
	localparam int MAX_CYCLES = PROG_LEN * 4 + 200;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0]  addr;
		logic [31:0] data;
	} retire_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
	} store_t;

	logic                   clk, rst_n, imem_we;
	logic [`MIPS_IM_AW-1:0] imem_addr;
	logic [31:0]            imem_wdata;
	logic                   wb_en, dm_we;
	logic [4:0]             wb_addr;
	logic [31:0]            wb_pc, wb_data, dm_addr, dm_wdata;

	instr_u      prog [PROG_LEN];
	logic [31:0] ref_regs [`MIPS_NREG];
	logic [31:0] ref_dmem [2**`MIPS_DM_AW];
	logic [31:0] ref_pc, ref_npc;
	retire_t     exp_wb [$];
	store_t      exp_st [$];
	retire_t     got_wb;
	store_t      got_st;
	integer      seed;
	int          retire_errs, store_errs, other_errs;

	tb_clock u_clock (.clk(clk));

	mips mips_i (
		.clk(clk), .rst_n(rst_n),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
		.wb_en(wb_en), .wb_pc(wb_pc), .wb_addr(wb_addr), .wb_data(wb_data),
		.dm_we(dm_we), .dm_addr(dm_addr), .dm_wdata(dm_wdata)
	);

	bind mips mips_asserts u_asserts (
		.clk(clk), .rst_n(rst_n), .wb_en(wb_en), .wb_addr(wb_addr),
		.dm_we(dm_we), .stall(hz.stall)
	);

	function automatic int rand_below(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic instr_u make_r(funct_e fn, int rs, int rt, int rd, int sh);
		instr_u w;
		w = '0;
		w.r.op = op_rtype;
		w.r.rs = rs[4:0];
		w.r.rt = rt[4:0];
		w.r.rd = rd[4:0];
		w.r.shamt = sh[4:0];
		w.r.funct = fn;
		return w;
	endfunction

	function automatic instr_u make_i(opcode_e op, int rs, int rt, int imm);
		instr_u w;
		w.i.op = op;
		w.i.rs = rs[4:0];
		w.i.rt = rt[4:0];
		w.i.imm = imm[15:0];
		return w;
	endfunction

	function automatic instr_u make_j(opcode_e op, int index);
		instr_u w;
		w.i.op = op;
		{w.i.rs, w.i.rt, w.i.imm} = index[25:0];
		return w;
	endfunction

	// random program over r0..r7, control flow only forward, no control in a delay slot
	task automatic build_program();
		int k;
		bit in_slot;
		in_slot = 1'b0;
		for (int i = 0; i < PROG_LEN - 2; i++) begin
			k = rand_below(16);
			if (k >= 12 && (in_slot || i > PROG_LEN - 8))
				k = rand_below(12);
			case (k)
				0: prog[i] = make_r(fn_addu, rand_below(8), rand_below(8), rand_below(8), 0);
				1: prog[i] = make_r(fn_subu, rand_below(8), rand_below(8), rand_below(8), 0);
				2: prog[i] = make_r(fn_and, rand_below(8), rand_below(8), rand_below(8), 0);
				3: prog[i] = make_r(fn_or, rand_below(8), rand_below(8), rand_below(8), 0);
				4: prog[i] = make_r(fn_slt, rand_below(8), rand_below(8), rand_below(8), 0);
				5: prog[i] = make_r(fn_sll, 0, rand_below(8), rand_below(8), rand_below(32));
				6: prog[i] = make_i(op_addiu, rand_below(8), rand_below(8), rand_below(65536));
				7: prog[i] = make_i(op_ori, rand_below(8), rand_below(8), rand_below(65536));
				8: prog[i] = make_i(op_lui, 0, rand_below(8), rand_below(65536));
				9, 10: prog[i] = make_i(op_lw, 0, rand_below(8), 4 * rand_below(16));
				11: prog[i] = make_i(op_sw, 0, rand_below(8), 4 * rand_below(16));
				12, 13: prog[i] = make_i(op_beq, rand_below(8), rand_below(8), 1 + rand_below(3));
				14: prog[i] = make_j(op_j, i + 2 + rand_below(4));
				default: prog[i] = make_j(op_jal, i + 2 + rand_below(4));
			endcase
			in_slot = (k >= 12);
		end
		prog[PROG_LEN-2] = make_j(op_j, PROG_LEN - 2);
		prog[PROG_LEN-1] = '0;
	endtask

	// one instruction of the ISA, delay slot modelled by the pc/npc pair
	function automatic void mips_step();
		instr_u      w;
		logic [31:0] a, b, sx, res, ea, nxt;
		logic [4:0]  dst;
		logic        wr;
		w = prog[int'(ref_pc >> 2)];
		a = ref_regs[w.r.rs];
		b = ref_regs[w.r.rt];
		sx = {{16{w.i.imm[15]}}, w.i.imm};
		ea = a + sx;
		nxt = ref_npc + 32'd4;
		wr = 1'b1;
		dst = w.i.rt;
		res = '0;
		case (w.r.op)
			op_rtype: begin
				dst = w.r.rd;
				case (w.r.funct)
					fn_addu: res = a + b;
					fn_subu: res = a - b;
					fn_and:  res = a & b;
					fn_or:   res = a | b;
					fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: res = b << w.r.shamt;
				endcase
			end
			op_addiu: res = ea;
			op_ori:   res = a | {16'd0, w.i.imm};
			op_lui:   res = {w.i.imm, 16'd0};
			op_lw:    res = ref_dmem[ea[`MIPS_DM_AW+1:2]];
			op_sw: begin
				wr = 1'b0;
				ref_dmem[ea[`MIPS_DM_AW+1:2]] = b;
				exp_st.push_back('{ea, b});
			end
			op_beq: begin
				wr = 1'b0;
				if (a == b)
					nxt = ref_pc + 32'd4 + {sx[29:0], 2'b00};
			end
			default: begin
				wr = (w.r.op == op_jal);
				dst = 5'd31;
				res = ref_pc + 32'd8;
				nxt = {ref_pc[31:28], w[25:0], 2'b00};
			end
		endcase
		if (wr && dst != 5'd0) begin
			ref_regs[dst] = res;
			exp_wb.push_back('{ref_pc, dst, res});
		end
		ref_pc = ref_npc;
		ref_npc = nxt;
	endfunction

	task automatic run_reference();
		int steps;
		steps = 0;
		foreach (ref_regs[i])
			ref_regs[i] = '0;
		foreach (ref_dmem[i])
			ref_dmem[i] = '0;
		ref_pc = `MIPS_RESET_PC;
		ref_npc = ref_pc + 32'd4;
		while (ref_pc != END_PC && steps < 1000) begin
			mips_step();
			steps++;
		end
	endtask

	always @(negedge clk) begin
		if (rst_n && wb_en) begin
			assert (exp_wb.size() != 0) else begin
				other_errs++;
				$display("extra register write to r%0d at %0t, nothing left to retire",
					wb_addr, $time);
			end
			if (exp_wb.size() != 0) begin
				got_wb = exp_wb.pop_front();
				assert (wb_pc == got_wb.pc) else begin
					retire_errs++;
					$display("** Error %0t: wb_pc %h, expected %h", $time, wb_pc, got_wb.pc);
				end
				assert (wb_addr == got_wb.addr) else begin
					retire_errs++;
					$display("** Error %0t: wb_addr %0d, expected %0d", $time, wb_addr,
						got_wb.addr);
				end
				assert (wb_data == got_wb.data) else begin
					retire_errs++;
					$display("** Error %0t: wb_data %h, expected %h", $time, wb_data,
						got_wb.data);
				end
			end
		end
		if (rst_n && dm_we) begin
			assert (exp_st.size() != 0) else begin
				other_errs++;
				$display("extra store to %h at %0t, no store was expected", dm_addr, $time);
			end
			if (exp_st.size() != 0) begin
				got_st = exp_st.pop_front();
				assert (dm_addr == got_st.addr) else begin
					store_errs++;
					$display("** Error %0t: dm_addr %h, expected %h", $time, dm_addr,
						got_st.addr);
				end
				assert (dm_wdata == got_st.data) else begin
					store_errs++;
					$display("** Error %0t: dm_wdata %h, expected %h", $time, dm_wdata,
						got_st.data);
				end
			end
		end
	end

	initial begin : watchdog
		@(posedge rst_n);
		repeat (MAX_CYCLES) @(posedge clk);
		$display("timeout: core did not reach the end loop within %0d cycles", MAX_CYCLES);
		$display("errors: retire %0d, store %0d, other %0d", retire_errs, store_errs,
			other_errs);
		$display("Verification failed");
		$finish;
	end

	initial begin
		seed = 32'hed0a_17dd;
		rst_n = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		retire_errs = 0;
		store_errs = 0;
		other_errs = 0;
		build_program();
		run_reference();
		// reset covers the program load and ten more cycles
		for (int i = 0; i < PROG_LEN; i++) begin
			@(posedge clk);
			#1;
			imem_we = 1'b1;
			imem_addr = i[`MIPS_IM_AW-1:0];
			imem_wdata = prog[i];
		end
		@(posedge clk);
		#1 imem_we = 1'b0;
		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;
		while (exp_wb.size() != 0 || exp_st.size() != 0)
			@(posedge clk);
		// core now spins in the end loop and must stay quiet
		repeat (20) @(posedge clk);
		$display("errors: retire %0d, store %0d, other %0d", retire_errs, store_errs,
			other_errs);
		if (retire_errs + store_errs + other_errs == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- mips.f
+incdir+.
mips_isa_pkg.sv
mips_ctrl_pkg.sv
mips_hazard_if.sv
mips_decode.sv
mips_hazard.sv
mips_rf.sv
mips.sv
mips_asserts.sv
tb_mips.sv

//--- Makefile
TOP = tb_mips

sim:
	verilator --binary --timing --assert -Wno-fatal -f mips.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
